// File: source/spu_defs.svh
`ifndef SPU_DEFS_SVH
`define SPU_DEFS_SVH

// widths of the instruction set
`define SPU_INSTR_W 32
`define SPU_OP_W 11
`define SPU_REG_ADDR_W 7
`define SPU_IMM_W 18

// opcode prefixes; ISA bit 0 is word bit 31
`define SPU_OP11_FIELD 31:21
`define SPU_OP9_FIELD 31:23
`define SPU_OP8_FIELD 31:24
`define SPU_OP7_FIELD 31:25
`define SPU_OP4_FIELD 31:28

// register fields
`define SPU_RT_FIELD 6:0
`define SPU_RA_FIELD 13:7
`define SPU_RB_FIELD 20:14
`define SPU_RC_FIELD 6:0
`define SPU_RRR_RT_FIELD 27:21

// immediate fields
`define SPU_I7_FIELD 20:14
`define SPU_I10_FIELD 23:14
`define SPU_I16_FIELD 22:7
`define SPU_I18_FIELD 24:7

`endif

// File: source/spu_decode_pkg.sv
`include "spu_defs.svh"

package spu_decode_pkg;

	typedef enum logic [2:0] {
		FMT_RR = 3'd0,
		FMT_RRR = 3'd1,
		FMT_RI7 = 3'd2,
		FMT_RI10 = 3'd4,
		FMT_RI16 = 3'd5,
		FMT_RI18 = 3'd6
	} instr_format_e;

	typedef enum logic [1:0] {
		EU_FP = 2'd0,
		EU_FX2 = 2'd1,
		EU_BYTE = 2'd2,
		EU_FX1 = 2'd3
	} even_unit_e;

	typedef enum logic [1:0] {
		OU_PERM = 2'd0,
		OU_LS = 2'd1,
		OU_BR = 2'd2
	} odd_unit_e;

	typedef struct packed {
		logic [`SPU_OP_W-1:0] opcode;
		instr_format_e format;
		even_unit_e unit;
		logic [`SPU_REG_ADDR_W-1:0] rt;
		logic [`SPU_REG_ADDR_W-1:0] ra;
		logic [`SPU_REG_ADDR_W-1:0] rb;
		logic [`SPU_REG_ADDR_W-1:0] rc;
		logic [`SPU_IMM_W-1:0] imm;
		logic reg_write;
	} even_op_t;

	typedef struct packed {
		logic [`SPU_OP_W-1:0] opcode;
		instr_format_e format;
		odd_unit_e unit;
		logic [`SPU_REG_ADDR_W-1:0] rt;
		logic [`SPU_REG_ADDR_W-1:0] ra;
		logic [`SPU_REG_ADDR_W-1:0] rb;
		logic [`SPU_IMM_W-1:0] imm;
		logic reg_write;
		logic odd_first; // odd op is the older one of its group
	} odd_op_t;

	// zero-extended opcode prefix of the format
	function automatic logic [`SPU_OP_W-1:0] opcode_field(
		input logic [`SPU_INSTR_W-1:0] instr,
		input instr_format_e fmt
	);
		logic [`SPU_OP_W-1:0] opc;
		case (fmt)
			FMT_RRR: opc = `SPU_OP_W'(instr[`SPU_OP4_FIELD]);
			FMT_RI18: opc = `SPU_OP_W'(instr[`SPU_OP7_FIELD]);
			FMT_RI10: opc = `SPU_OP_W'(instr[`SPU_OP8_FIELD]);
			FMT_RI16: opc = `SPU_OP_W'(instr[`SPU_OP9_FIELD]);
			default: opc = instr[`SPU_OP11_FIELD]; // RR and RI7
		endcase
		return opc;
	endfunction

	// sign-extended immediate of the format
	function automatic logic [`SPU_IMM_W-1:0] imm_field(
		input logic [`SPU_INSTR_W-1:0] instr,
		input instr_format_e fmt
	);
		logic [`SPU_IMM_W-1:0] imm;
		case (fmt)
			FMT_RI7: imm = `SPU_IMM_W'($signed(instr[`SPU_I7_FIELD]));
			FMT_RI10: imm = `SPU_IMM_W'($signed(instr[`SPU_I10_FIELD]));
			FMT_RI16: imm = `SPU_IMM_W'($signed(instr[`SPU_I16_FIELD]));
			FMT_RI18: imm = instr[`SPU_I18_FIELD];
			default: imm = '0; // register formats
		endcase
		return imm;
	endfunction

endpackage

// File: source/even_decoder.sv
`timescale 1ns/1ps
`include "spu_defs.svh"

module even_decoder import spu_decode_pkg::*; (
	input logic [`SPU_INSTR_W-1:0] instr,
	output logic hit,
	output even_op_t op
);

	logic op11_hit;
	instr_format_e op11_fmt;
	even_unit_e op11_unit;
	logic ri16_hit;
	logic ri10_hit;
	even_unit_e ri10_unit;
	logic ri18_hit;
	logic rrr_hit;

	// RR and RI7 tables
	always_comb begin
		op11_hit = 1'b1;
		op11_fmt = FMT_RR;
		op11_unit = EU_FX1;
		case (instr[`SPU_OP11_FIELD])
			11'b01111000100, 11'b01111001100, 11'b01111000101, // mpy mpyu mpyh
			11'b01011000100, 11'b01011000101, 11'b01011000110, // fa fs fm
			11'b01111000010, 11'b01011000010: op11_unit = EU_FP; // fceq fcgt
			11'b00001011111, 11'b00001011011, 11'b00001011100, // shlh shl roth
			11'b00001011000, 11'b00001011101, 11'b00001011001, // rot rothm rotm
			11'b00001011110, 11'b00001011010: op11_unit = EU_FX2; // rotmah rotma
			11'b01010110100, 11'b00011010011,
			11'b00001010011, 11'b01001010011: op11_unit = EU_BYTE; // cntb avgb absdb sumb
			11'b00011001000, 11'b00011000000, 11'b00001001000, // ah a sfh
			11'b00001000000, 11'b00011000001, 11'b00001000001, // sf and or
			11'b01001000001, 11'b00011001001, // xor nand
			11'b01111010000, 11'b01111001000, 11'b01111000000, // ceqb ceqh ceq
			11'b01001010000, 11'b01001001000, 11'b01001000000, // cgtb cgth cgt
			11'b01011010000, 11'b01011001000, 11'b01011000000: op11_unit = EU_FX1;
			11'b00001111011, 11'b00001111100, 11'b00001111000, // shli rothi roti
			11'b00001111110, 11'b00001111010: begin // rotmahi rotmai
				op11_fmt = FMT_RI7;
				op11_unit = EU_FX2;
			end
			default: op11_hit = 1'b0;
		endcase
	end

	// ilh ilhu iohl
	assign ri16_hit = (instr[`SPU_OP9_FIELD] == 9'b010000011) ||
		(instr[`SPU_OP9_FIELD] == 9'b010000010) || (instr[`SPU_OP9_FIELD] == 9'b011000001);

	always_comb begin
		ri10_hit = 1'b1;
		ri10_unit = EU_FX1;
		case (instr[`SPU_OP8_FIELD])
			8'b01110100, 8'b01110101: ri10_unit = EU_FP; // mpyi mpyui
			8'b00011101, 8'b00011100, 8'b00001101, 8'b00001100, // ahi ai sfhi sfi
			8'b00010110, 8'b00010101, 8'b00010100, // andbi andhi andi
			8'b00000110, 8'b00000101, 8'b00000100, // orbi orhi ori
			8'b01000110, 8'b01000101, 8'b01000100, // xorbi xorhi xori
			8'b01111110, 8'b01111101, 8'b01111100, // ceqbi ceqhi ceqi
			8'b01001110, 8'b01001101, 8'b01001100, // cgtbi cgthi cgti
			8'b01011110, 8'b01011101, 8'b01011100: ri10_unit = EU_FX1;
			default: ri10_hit = 1'b0;
		endcase
	end

	assign ri18_hit = (instr[`SPU_OP7_FIELD] == 7'b0100001); // ila
	assign rrr_hit = (instr[`SPU_OP4_FIELD] == 4'b1100) || // mpya
		(instr[`SPU_OP4_FIELD] == 4'b1110) || (instr[`SPU_OP4_FIELD] == 4'b1111); // fma fms

	// longest prefix wins
	always_comb begin
		op = '0;
		hit = 1'b1;
		if (op11_hit) begin
			op.format = op11_fmt;
			op.unit = op11_unit;
		end else if (ri16_hit) begin
			op.format = FMT_RI16;
			op.unit = EU_FX1;
		end else if (ri10_hit) begin
			op.format = FMT_RI10;
			op.unit = ri10_unit;
		end else if (ri18_hit) begin
			op.format = FMT_RI18;
			op.unit = EU_FX1;
		end else if (rrr_hit) begin
			op.format = FMT_RRR;
			op.unit = EU_FP;
		end else begin
			hit = 1'b0; // zero word lands here too
		end
		if (hit) begin
			op.opcode = opcode_field(instr, op.format);
			op.imm = imm_field(instr, op.format);
			op.reg_write = 1'b1;
			op.rt = (op.format == FMT_RRR) ? instr[`SPU_RRR_RT_FIELD] : instr[`SPU_RT_FIELD];
			case (op.format)
				FMT_RR, FMT_RRR: begin
					op.ra = instr[`SPU_RA_FIELD];
					op.rb = instr[`SPU_RB_FIELD];
				end
				FMT_RI7, FMT_RI10: op.ra = instr[`SPU_RA_FIELD];
				default: ;
			endcase
			if (op.format == FMT_RRR)
				op.rc = instr[`SPU_RC_FIELD];
		end
	end

endmodule

// File: source/odd_decoder.sv
`timescale 1ns/1ps
`include "spu_defs.svh"

module odd_decoder import spu_decode_pkg::*; (
	input logic [`SPU_INSTR_W-1:0] instr,
	output logic hit,
	output odd_op_t op
);

	logic tbl_hit;
	instr_format_e tbl_fmt;
	odd_unit_e tbl_unit;
	logic tbl_write;

	always_comb begin
		tbl_hit = 1'b1;
		tbl_fmt = FMT_RR;
		tbl_unit = OU_PERM;
		tbl_write = 1'b1;
		case (instr[`SPU_OP11_FIELD])
			11'b00111011011, 11'b00111011111, // shlqbi shlqby
			11'b00111011000, 11'b00111011100, // rotqbi rotqby
			11'b00110110010, 11'b00110110001, 11'b00110110000: tbl_unit = OU_PERM; // gbb gbh gb
			11'b00111000100: tbl_unit = OU_LS; // lqx
			11'b00101000100: begin // stqx
				tbl_unit = OU_LS;
				tbl_write = 1'b0;
			end
			11'b00110101000: begin // bi
				tbl_unit = OU_BR;
				tbl_write = 1'b0;
			end
			11'b00000000001: tbl_write = 1'b0; // lnop
			11'b00111111011, 11'b00111111111, // shlqbii shlqbyi
			11'b00111111000, 11'b00111111100: tbl_fmt = FMT_RI7; // rotqbii rotqbyi
			default: begin
				tbl_fmt = FMT_RI16;
				case (instr[`SPU_OP9_FIELD])
					9'b001100001: tbl_unit = OU_LS; // lqa
					9'b001000001: begin // stqa
						tbl_unit = OU_LS;
						tbl_write = 1'b0;
					end
					9'b001100110: tbl_unit = OU_BR; // brsl links
					9'b001100100, 9'b001100000, // br bra
					9'b001000010, 9'b001000000: begin // brnz brz
						tbl_unit = OU_BR;
						tbl_write = 1'b0;
					end
					default: begin
						tbl_fmt = FMT_RI10;
						tbl_unit = OU_LS;
						case (instr[`SPU_OP8_FIELD])
							8'b00110100: tbl_write = 1'b1; // lqd
							8'b00100100: tbl_write = 1'b0; // stqd
							default: tbl_hit = 1'b0;
						endcase
					end
				endcase
			end
		endcase
	end

	always_comb begin
		op = '0; // odd_first stays low here
		hit = tbl_hit;
		if (tbl_hit) begin
			op.format = tbl_fmt;
			op.unit = tbl_unit;
			op.reg_write = tbl_write;
			op.opcode = opcode_field(instr, tbl_fmt);
			op.imm = imm_field(instr, tbl_fmt);
			op.rt = instr[`SPU_RT_FIELD];
			if (tbl_fmt != FMT_RI16)
				op.ra = instr[`SPU_RA_FIELD];
			if (tbl_fmt == FMT_RR)
				op.rb = instr[`SPU_RB_FIELD];
		end
	end

endmodule

// File: source/dual_issue_steer.sv
`timescale 1ns/1ps
`include "spu_defs.svh"

module dual_issue_steer import spu_decode_pkg::*; (
	input logic clk,
	input logic reset,
	input logic pair_valid,
	output logic pair_ready,
	input logic first_zero,
	input logic first_even_hit,
	input even_op_t first_even,
	input logic first_odd_hit,
	input odd_op_t first_odd,
	input logic second_zero,
	input logic second_even_hit,
	input even_op_t second_even,
	input logic second_odd_hit,
	input odd_op_t second_odd,
	output logic even_push,
	output even_op_t even_push_op,
	input logic even_room,
	output logic odd_push,
	output odd_op_t odd_push_op,
	input logic odd_room,
	output logic finished
);

	logic accept;
	logic stop;
	logic first_live, second_live;
	logic first_rw, second_rw;
	logic [`SPU_REG_ADDR_W-1:0] first_rt, second_rt;
	logic same_rt;
	logic dual, split;
	logic acc_even, acc_odd;
	even_op_t acc_even_op;
	odd_op_t acc_odd_op;
	logic hold_valid;
	logic hold_is_odd;
	even_op_t hold_even;
	odd_op_t hold_odd;
	logic hold_go;

	// a stop word kills itself and everything behind it
	assign stop = first_zero || second_zero;
	assign first_live = !first_zero && (first_even_hit || first_odd_hit);
	assign second_live = !stop && (second_even_hit || second_odd_hit);

	// even table wins if a word hits both
	assign first_rt = first_even_hit ? first_even.rt : first_odd.rt;
	assign first_rw = first_even_hit ? first_even.reg_write : first_odd.reg_write;
	assign second_rt = second_even_hit ? second_even.rt : second_odd.rt;
	assign second_rw = second_even_hit ? second_even.reg_write : second_odd.reg_write;
	assign same_rt = first_rw && second_rw && (first_rt == second_rt);

	assign dual = first_live && second_live && (first_even_hit != second_even_hit) && !same_rt;
	assign split = first_live && second_live && !dual;

	// what goes out on the accepting edge
	assign acc_even = (first_live && first_even_hit) || (second_live && second_even_hit && !split);
	assign acc_odd = (first_live && !first_even_hit) || (second_live && !second_even_hit && !split);

	always_comb begin
		acc_even_op = (first_live && first_even_hit) ? first_even : second_even;
		acc_odd_op = (first_live && !first_even_hit) ? first_odd : second_odd;
		acc_odd_op.odd_first = dual && !first_even_hit;
	end

	assign hold_go = hold_valid && (hold_is_odd ? odd_room : even_room);
	assign pair_ready = !hold_valid && !finished && even_room && odd_room;
	assign accept = pair_valid && pair_ready;

	assign even_push = hold_valid ? (hold_go && !hold_is_odd) : (accept && acc_even);
	assign odd_push = hold_valid ? (hold_go && hold_is_odd) : (accept && acc_odd);
	assign even_push_op = hold_valid ? hold_even : acc_even_op;
	assign odd_push_op = hold_valid ? hold_odd : acc_odd_op;

	always_ff @(posedge clk) begin
		if (reset) begin
			hold_valid <= 1'b0;
			finished <= 1'b0;
		end else begin
			if (accept && split)
				hold_valid <= 1'b1; // younger one waits a group
			else if (hold_go)
				hold_valid <= 1'b0;
			if (accept && stop)
				finished <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (accept && split) begin
			hold_is_odd <= !second_even_hit;
			hold_even <= second_even;
			hold_odd <= second_odd;
		end
	end

endmodule

// File: source/issue_skid.sv
`timescale 1ns/1ps
`include "spu_defs.svh"

module issue_skid import spu_decode_pkg::*; #(
	parameter type payload_t = even_op_t
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	output logic room,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	payload_t mem [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;
	logic [1:0] count_next;
	logic pop;

	assign out_valid = (count != 2'd0);
	assign out_data = mem[rd_ptr];
	assign pop = out_valid && out_ready;
	assign count_next = count + {1'b0, push} - {1'b0, pop};

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
			room <= 1'b1;
		end else begin
			if (push)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;
			count <= count_next;
			room <= (count_next != 2'd2); // low only when both slots hold data
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

endmodule

// File: source/spu_decode.sv
`timescale 1ns/1ps
`include "spu_defs.svh"

module spu_decode import spu_decode_pkg::*; (
	input logic clk,
	input logic reset,
	input logic pair_valid,
	output logic pair_ready,
	input logic [`SPU_INSTR_W-1:0] instr_first,
	input logic [`SPU_INSTR_W-1:0] instr_second,
	output logic even_valid,
	input logic even_ready,
	output logic [`SPU_OP_W-1:0] even_opcode,
	output instr_format_e even_format,
	output even_unit_e even_unit,
	output logic [`SPU_REG_ADDR_W-1:0] even_rt,
	output logic [`SPU_REG_ADDR_W-1:0] even_ra,
	output logic [`SPU_REG_ADDR_W-1:0] even_rb,
	output logic [`SPU_REG_ADDR_W-1:0] even_rc,
	output logic [`SPU_IMM_W-1:0] even_imm,
	output logic even_reg_write,
	output logic odd_valid,
	input logic odd_ready,
	output logic [`SPU_OP_W-1:0] odd_opcode,
	output instr_format_e odd_format,
	output odd_unit_e odd_unit,
	output logic [`SPU_REG_ADDR_W-1:0] odd_rt,
	output logic [`SPU_REG_ADDR_W-1:0] odd_ra,
	output logic [`SPU_REG_ADDR_W-1:0] odd_rb,
	output logic [`SPU_IMM_W-1:0] odd_imm,
	output logic odd_reg_write,
	output logic odd_first,
	output logic finished
);

	logic first_zero, second_zero;
	logic first_even_hit, second_even_hit;
	logic first_odd_hit, second_odd_hit;
	even_op_t first_even, second_even;
	odd_op_t first_odd, second_odd;
	logic even_push, odd_push;
	even_op_t even_push_op, even_out;
	odd_op_t odd_push_op, odd_out;
	logic even_room, odd_room;

	assign first_zero = (instr_first == '0); // stop marker
	assign second_zero = (instr_second == '0);

	even_decoder u_even_first (.instr(instr_first), .hit(first_even_hit), .op(first_even));
	odd_decoder u_odd_first (.instr(instr_first), .hit(first_odd_hit), .op(first_odd));
	even_decoder u_even_second (.instr(instr_second), .hit(second_even_hit), .op(second_even));
	odd_decoder u_odd_second (.instr(instr_second), .hit(second_odd_hit), .op(second_odd));

	dual_issue_steer u_steer (
		.clk(clk), .reset(reset), .pair_valid(pair_valid), .pair_ready(pair_ready),
		.first_zero(first_zero), .first_even_hit(first_even_hit), .first_even(first_even),
		.first_odd_hit(first_odd_hit), .first_odd(first_odd),
		.second_zero(second_zero), .second_even_hit(second_even_hit),
		.second_even(second_even), .second_odd_hit(second_odd_hit), .second_odd(second_odd),
		.even_push(even_push), .even_push_op(even_push_op), .even_room(even_room),
		.odd_push(odd_push), .odd_push_op(odd_push_op), .odd_room(odd_room),
		.finished(finished)
	);

	issue_skid #(.payload_t(even_op_t)) u_even_skid (
		.clk(clk), .reset(reset), .push(even_push), .push_data(even_push_op),
		.room(even_room), .out_valid(even_valid), .out_ready(even_ready), .out_data(even_out)
	);

	issue_skid #(.payload_t(odd_op_t)) u_odd_skid (
		.clk(clk), .reset(reset), .push(odd_push), .push_data(odd_push_op),
		.room(odd_room), .out_valid(odd_valid), .out_ready(odd_ready), .out_data(odd_out)
	);

	assign even_opcode = even_out.opcode;
	assign even_format = even_out.format;
	assign even_unit = even_out.unit;
	assign even_rt = even_out.rt;
	assign even_ra = even_out.ra;
	assign even_rb = even_out.rb;
	assign even_rc = even_out.rc;
	assign even_imm = even_out.imm;
	assign even_reg_write = even_out.reg_write;

	assign odd_opcode = odd_out.opcode;
	assign odd_format = odd_out.format;
	assign odd_unit = odd_out.unit;
	assign odd_rt = odd_out.rt;
	assign odd_ra = odd_out.ra;
	assign odd_rb = odd_out.rb;
	assign odd_imm = odd_out.imm;
	assign odd_reg_write = odd_out.reg_write;
	assign odd_first = odd_out.odd_first;

endmodule

// File: verification/spu_decode_tb.sv
`timescale 1ns/1ps
`include "spu_defs.svh"

module spu_decode_tb import spu_decode_pkg::*; ();

	typedef struct packed {
		logic odd; // odd pipe instruction
		instr_format_e fmt;
		logic [1:0] unit;
		logic rw;
		logic [10:0] op; // opcode prefix, right aligned
	} table_row_t;

	localparam int CLK_NS = 4;
	localparam int TABLE_SIZE = 18;
	localparam int RANDOM_PAIRS = 300;
	localparam int PAIR_COUNT = RANDOM_PAIRS + 20;
	localparam int WATCHDOG_NS = PAIR_COUNT * 20 * CLK_NS + 1000;
	localparam int JUNK_IDX = -1;
	localparam int STOP_IDX = -2;
	localparam logic [10:0] JUNK_PREFIX = 11'b11010000000; // in no opcode table

	logic clk;
	logic reset;
	logic pair_valid;
	logic pair_ready;
	logic [`SPU_INSTR_W-1:0] instr_first;
	logic [`SPU_INSTR_W-1:0] instr_second;
	logic even_valid;
	logic even_ready;
	logic [`SPU_OP_W-1:0] even_opcode;
	instr_format_e even_format;
	even_unit_e even_unit;
	logic [`SPU_REG_ADDR_W-1:0] even_rt, even_ra, even_rb, even_rc;
	logic [`SPU_IMM_W-1:0] even_imm;
	logic even_reg_write;
	logic odd_valid;
	logic odd_ready;
	logic [`SPU_OP_W-1:0] odd_opcode;
	instr_format_e odd_format;
	odd_unit_e odd_unit;
	logic [`SPU_REG_ADDR_W-1:0] odd_rt, odd_ra, odd_rb;
	logic [`SPU_IMM_W-1:0] odd_imm;
	logic odd_reg_write;
	logic odd_first;
	logic finished;

	integer seed = 32'h3d9b;
	int errors = 0;
	int checked = 0;
	logic random_ready = 1'b0;
	even_op_t even_q[$];
	odd_op_t odd_q[$];
	even_op_t even_exp, even_act;
	odd_op_t odd_exp, odd_act;
	logic even_have = 1'b0;
	logic odd_have = 1'b0;
	logic exp_finished = 1'b0;
	logic even_ok, odd_ok;
	logic [31:0] w1, w2;

	spu_decode u_dut (
		.clk(clk), .reset(reset), .pair_valid(pair_valid), .pair_ready(pair_ready),
		.instr_first(instr_first), .instr_second(instr_second),
		.even_valid(even_valid), .even_ready(even_ready), .even_opcode(even_opcode),
		.even_format(even_format), .even_unit(even_unit), .even_rt(even_rt),
		.even_ra(even_ra), .even_rb(even_rb), .even_rc(even_rc), .even_imm(even_imm),
		.even_reg_write(even_reg_write), .odd_valid(odd_valid), .odd_ready(odd_ready),
		.odd_opcode(odd_opcode), .odd_format(odd_format), .odd_unit(odd_unit),
		.odd_rt(odd_rt), .odd_ra(odd_ra), .odd_rb(odd_rb), .odd_imm(odd_imm),
		.odd_reg_write(odd_reg_write), .odd_first(odd_first), .finished(finished)
	);

	// opcode subset used by the stimulus
	function automatic table_row_t table_row(input int idx);
		table_row_t row;
		case (idx)
			0: row = {1'b0, FMT_RR, EU_FX1, 1'b1, 11'b00011000000}; // a
			1: row = {1'b0, FMT_RR, EU_FX2, 1'b1, 11'b00001011011}; // shl
			2: row = {1'b0, FMT_RR, EU_BYTE, 1'b1, 11'b01010110100}; // cntb
			3: row = {1'b0, FMT_RR, EU_FP, 1'b1, 11'b01011000100}; // fa
			4: row = {1'b0, FMT_RI7, EU_FX2, 1'b1, 11'b00001111011}; // shli
			5: row = {1'b0, FMT_RI10, EU_FX1, 1'b1, 11'(8'b00011100)}; // ai
			6: row = {1'b0, FMT_RI16, EU_FX1, 1'b1, 11'(9'b010000011)}; // ilh
			7: row = {1'b0, FMT_RI18, EU_FX1, 1'b1, 11'(7'b0100001)}; // ila
			8: row = {1'b0, FMT_RRR, EU_FP, 1'b1, 11'(4'b1110)}; // fma
			9: row = {1'b1, FMT_RR, OU_PERM, 1'b1, 11'b00111011100}; // rotqby
			10: row = {1'b1, FMT_RR, OU_LS, 1'b1, 11'b00111000100}; // lqx
			11: row = {1'b1, FMT_RR, OU_LS, 1'b0, 11'b00101000100}; // stqx
			12: row = {1'b1, FMT_RR, OU_BR, 1'b0, 11'b00110101000}; // bi
			13: row = {1'b1, FMT_RI7, OU_PERM, 1'b1, 11'b00111111011}; // shlqbii
			14: row = {1'b1, FMT_RI10, OU_LS, 1'b1, 11'(8'b00110100)}; // lqd
			15: row = {1'b1, FMT_RI10, OU_LS, 1'b0, 11'(8'b00100100)}; // stqd
			16: row = {1'b1, FMT_RI16, OU_LS, 1'b1, 11'(9'b001100001)}; // lqa
			default: row = {1'b1, FMT_RI16, OU_BR, 1'b1, 11'(9'b001100110)}; // brsl
		endcase
		return row;
	endfunction

	function automatic logic [10:0] prefix_of(input logic [31:0] w, input instr_format_e fmt);
		logic [10:0] p;
		case (fmt)
			FMT_RRR: p = 11'(w[31:28]);
			FMT_RI10: p = 11'(w[31:24]);
			FMT_RI16: p = 11'(w[31:23]);
			FMT_RI18: p = 11'(w[31:25]);
			default: p = w[31:21];
		endcase
		return p;
	endfunction

	function automatic int find_entry(input logic [31:0] w);
		table_row_t row;
		int found;
		found = -1;
		for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
			row = table_row(i);
			if (prefix_of(w, row.fmt) == row.op)
				found = i;
		end
		return found;
	endfunction

	function automatic logic [31:0] make_word(input int idx, input logic [6:0] rt,
		input logic [31:0] bits);
		table_row_t row;
		logic [31:0] w;
		row = table_row(idx);
		w = bits;
		case (row.fmt)
			FMT_RRR: begin
				w[31:28] = row.op[3:0];
				w[27:21] = rt; // rc keeps the random low bits
			end
			FMT_RI10: w[31:24] = row.op[7:0];
			FMT_RI16: w[31:23] = row.op[8:0];
			FMT_RI18: w[31:25] = row.op[6:0];
			default: w[31:21] = row.op;
		endcase
		if (row.fmt != FMT_RRR)
			w[6:0] = rt;
		return w;
	endfunction

	// expected decode built from the field layout of each format
	function automatic even_op_t expect_op(input logic [31:0] w, input int idx);
		table_row_t row;
		even_op_t e;
		row = table_row(idx);
		e = '0;
		e.opcode = row.op;
		e.format = row.fmt;
		e.unit = even_unit_e'(row.unit);
		e.reg_write = row.rw;
		e.rt = w[6:0];
		case (row.fmt)
			FMT_RR: begin
				e.ra = w[13:7];
				e.rb = w[20:14];
			end
			FMT_RRR: begin
				e.rt = w[27:21];
				e.ra = w[13:7];
				e.rb = w[20:14];
				e.rc = w[6:0];
			end
			FMT_RI7: begin
				e.ra = w[13:7];
				e.imm = {{11{w[20]}}, w[20:14]};
			end
			FMT_RI10: begin
				e.ra = w[13:7];
				e.imm = {{8{w[23]}}, w[23:14]};
			end
			FMT_RI16: e.imm = {{2{w[22]}}, w[22:7]};
			default: e.imm = w[24:7]; // RI18 is not extended
		endcase
		return e;
	endfunction

	task automatic queue_op(input even_op_t e, input logic is_odd, input logic older);
		odd_op_t o;
		if (!is_odd) begin
			even_q.push_back(e);
		end else begin
			o = '0;
			o.opcode = e.opcode;
			o.format = e.format;
			o.unit = odd_unit_e'(e.unit);
			o.rt = e.rt;
			o.ra = e.ra;
			o.rb = e.rb;
			o.imm = e.imm;
			o.reg_write = e.reg_write;
			o.odd_first = older;
			odd_q.push_back(o);
		end
	endtask

	// steering rules applied to one accepted pair
	task automatic model_pair(input logic [31:0] wa, input logic [31:0] wb);
		int ia, ib;
		logic stop, live_a, live_b, odd_a, odd_b, clash;
		even_op_t ea, eb;
		table_row_t ra, rb;
		ia = find_entry(wa);
		ib = find_entry(wb);
		stop = (wa == '0) || (wb == '0);
		live_a = (wa != '0) && (ia >= 0);
		live_b = !stop && (ib >= 0); // nothing behind a stop word issues
		ea = live_a ? expect_op(wa, ia) : '0;
		eb = live_b ? expect_op(wb, ib) : '0;
		ra = live_a ? table_row(ia) : '0;
		rb = live_b ? table_row(ib) : '0;
		odd_a = ra.odd;
		odd_b = rb.odd;
		clash = ea.reg_write && eb.reg_write && (ea.rt == eb.rt);
		if (stop)
			exp_finished = 1'b1;
		if (live_a && live_b && (odd_a != odd_b) && !clash) begin
			queue_op(ea, odd_a, odd_a); // one group
			queue_op(eb, odd_b, 1'b0);
		end else begin
			if (live_a)
				queue_op(ea, odd_a, 1'b0);
			if (live_b)
				queue_op(eb, odd_b, 1'b0);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			even_q.delete();
			odd_q.delete();
			exp_finished = 1'b0;
		end else begin
			if (even_valid && even_ready && even_q.size() != 0) begin
				void'(even_q.pop_front());
				checked++;
			end
			if (odd_valid && odd_ready && odd_q.size() != 0) begin
				void'(odd_q.pop_front());
				checked++;
			end
			if (pair_valid && pair_ready && !exp_finished)
				model_pair(instr_first, instr_second); // nothing is expected after a stop
		end
		even_have = (even_q.size() != 0);
		odd_have = (odd_q.size() != 0);
		if (even_have)
			even_exp = even_q[0];
		if (odd_have)
			odd_exp = odd_q[0];
	end

	assign even_act = '{opcode: even_opcode, format: even_format, unit: even_unit,
		rt: even_rt, ra: even_ra, rb: even_rb, rc: even_rc, imm: even_imm,
		reg_write: even_reg_write};
	assign odd_act = '{opcode: odd_opcode, format: odd_format, unit: odd_unit,
		rt: odd_rt, ra: odd_ra, rb: odd_rb, imm: odd_imm, reg_write: odd_reg_write,
		odd_first: odd_first};
	assign even_ok = even_have && (even_act === even_exp);
	assign odd_ok = odd_have && (odd_act === odd_exp);

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic show_even_diff();
		if (!even_have) begin
			errors++;
			$display("at %0t the even pipe took an instruction that was never expected", $time);
		end else begin
			check_field("even_opcode", 32'(even_exp.opcode), 32'(even_opcode));
			check_field("even_format", 32'(even_exp.format), 32'(even_format));
			check_field("even_unit", 32'(even_exp.unit), 32'(even_unit));
			check_field("even_rt", 32'(even_exp.rt), 32'(even_rt));
			check_field("even_ra", 32'(even_exp.ra), 32'(even_ra));
			check_field("even_rb", 32'(even_exp.rb), 32'(even_rb));
			check_field("even_rc", 32'(even_exp.rc), 32'(even_rc));
			check_field("even_imm", 32'(even_exp.imm), 32'(even_imm));
			check_field("even_reg_write", 32'(even_exp.reg_write), 32'(even_reg_write));
		end
	endtask

	task automatic show_odd_diff();
		if (!odd_have) begin
			errors++;
			$display("at %0t the odd pipe took an instruction that was never expected", $time);
		end else begin
			check_field("odd_opcode", 32'(odd_exp.opcode), 32'(odd_opcode));
			check_field("odd_format", 32'(odd_exp.format), 32'(odd_format));
			check_field("odd_unit", 32'(odd_exp.unit), 32'(odd_unit));
			check_field("odd_rt", 32'(odd_exp.rt), 32'(odd_rt));
			check_field("odd_ra", 32'(odd_exp.ra), 32'(odd_ra));
			check_field("odd_rb", 32'(odd_exp.rb), 32'(odd_rb));
			check_field("odd_imm", 32'(odd_exp.imm), 32'(odd_imm));
			check_field("odd_reg_write", 32'(odd_exp.reg_write), 32'(odd_reg_write));
			check_field("odd_first", 32'(odd_exp.odd_first), 32'(odd_first));
		end
	endtask

	// outputs settle before the falling edge that precedes the handshake
	assert property (@(negedge clk) disable iff (reset) (even_valid && even_ready) |-> even_ok)
		else show_even_diff();
	assert property (@(negedge clk) disable iff (reset) (odd_valid && odd_ready) |-> odd_ok)
		else show_odd_diff();
	assert property (@(negedge clk) disable iff (reset) finished == exp_finished)
		else check_field("finished", 32'(exp_finished), 32'(finished));
	assert property (@(negedge clk) disable iff (reset) finished |-> !pair_ready)
		else begin
			errors++;
			$display("at %0t a new pair could still be accepted after the stop marker", $time);
		end

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		logic [31:0] rnd;
		forever begin
			@(posedge clk);
			#1;
			rnd = $random(seed);
			even_ready = rnd[0] || !random_ready;
			odd_ready = rnd[1] || !random_ready;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not complete within %0d ns", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic offer(input logic [31:0] wa, input logic [31:0] wb);
		pair_valid = 1'b1;
		instr_first = wa;
		instr_second = wb;
		@(negedge clk);
		while (!pair_ready)
			@(negedge clk);
		@(posedge clk); // accepting edge
		#1;
		pair_valid = 1'b0;
	endtask

	task automatic pick_word(input int idx, input logic [6:0] rt, output logic [31:0] w);
		logic [31:0] bits;
		bits = $random(seed);
		if (idx == STOP_IDX)
			w = '0;
		else if (idx == JUNK_IDX)
			w = {JUNK_PREFIX, bits[20:0]};
		else
			w = make_word(idx, rt, bits);
	endtask

	task automatic offer_entries(input int ia, input logic [6:0] rta, input int ib,
		input logic [6:0] rtb);
		logic [31:0] wa, wb;
		pick_word(ia, rta, wa);
		pick_word(ib, rtb, wb);
		offer(wa, wb);
	endtask

	task automatic random_word(output logic [31:0] w);
		logic [31:0] bits;
		int pick;
		bits = $random(seed);
		pick = $unsigned($random(seed)) % (TABLE_SIZE + 2);
		if (pick >= TABLE_SIZE)
			w = {JUNK_PREFIX, bits[20:0]};
		else
			w = make_word(pick, {4'b0, bits[31:29]}, bits); // narrow rt range gives many clashes
	endtask

	task automatic wait_drained();
		@(negedge clk);
		while (even_have || odd_have)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	initial begin
		reset = 1'b1;
		pair_valid = 1'b0;
		instr_first = '0;
		instr_second = '0;
		even_ready = 1'b1;
		odd_ready = 1'b1;
		apply_reset();
		offer_entries(0, 7'd5, 14, 7'd9); // even then odd
		offer_entries(10, 7'd3, 3, 7'd4); // odd first so swapped
		offer_entries(1, 7'd6, 8, 7'd7);
		offer_entries(12, 7'd1, 16, 7'd2);
		offer_entries(5, 7'd12, 17, 7'd12); // same rt splits
		offer_entries(13, 7'd20, 9, 7'd20);
		offer_entries(2, 7'd30, 4, 7'd30);
		offer_entries(15, 7'd12, 7, 7'd12); // stqd writes nothing
		offer_entries(JUNK_IDX, 7'd0, 11, 7'd4);
		offer_entries(6, 7'd8, JUNK_IDX, 7'd0);
		wait_drained();
		random_ready = 1'b1;
		repeat (RANDOM_PAIRS) begin
			random_word(w1);
			random_word(w2);
			offer(w1, w2);
		end
		random_ready = 1'b0;
		wait_drained();
		offer_entries(3, 7'd9, STOP_IDX, 7'd0);
		pair_valid = 1'b1;
		instr_first = make_word(0, 7'd1, 32'h0);
		instr_second = make_word(14, 7'd2, 32'h0);
		repeat (10) @(posedge clk); // never taken
		#1;
		pair_valid = 1'b0;
		wait_drained();
		apply_reset();
		offer_entries(STOP_IDX, 7'd0, 3, 7'd1); // stop ahead of everything
		repeat (4) @(posedge clk);
		wait_drained();
		$display("checked %0d issued entries, %0d errors", checked, errors);
		if (errors == 0 && checked > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+source
source/spu_decode_pkg.sv
source/even_decoder.sv
source/odd_decoder.sv
source/dual_issue_steer.sv
source/issue_skid.sv
source/spu_decode.sv
verification/spu_decode_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the decode testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module spu_decode_tb \
	-f sim.f -o spu_decode_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/spu_decode_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"
